//--- Makefile
# Verilator build and run of the memory unit testbench

VERILATOR ?= verilator
TOP       ?= memory_unit_tb
FILELIST  ?= memory_unit.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

$(SIM): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASSED$$"

clean:
	rm -rf $(BUILD_DIR)

//--- common/mu_pkg.sv
/*
 * Memory unit shared definitions
 * Address map of the peripheral I/O window, the decoded select code,
 * the decoded bus request and the per-channel command and status words
 */
`default_nettype none

package mu_pkg;

    // ----------------------------------------
    // Bus and address map
    // ----------------------------------------
    localparam int BUS_ADDR_W = 27;
    localparam int BUS_DATA_W = 32;
    localparam int CHAN_W = 3;
    localparam int OFFSET_W = 5;

    // Word address of SPI channel 0 data register
    localparam logic [BUS_ADDR_W-1:0] IO_BASE = 27'hC02728;

    // Data, chip select, interrupt status
    localparam int REGS_PER_CHAN = 3;

    // Offsets from IO_BASE, past the last possible channel
    localparam logic [OFFSET_W-1:0] GPIO_OFFSET = 5'd15;
    localparam logic [OFFSET_W-1:0] BOOT_OFFSET = 5'd16;

    // ----------------------------------------
    // Decoded access
    // ----------------------------------------
    typedef enum logic [2:0] {
        SEL_NONE,
        SEL_SPI_DATA,
        SEL_SPI_CS,
        SEL_SPI_INT,
        SEL_GPIO,
        SEL_BOOT
    } reg_sel_e;

    typedef struct packed {
        reg_sel_e                sel;
        logic [CHAN_W-1:0]       chan;
        logic                    we;
        logic [BUS_DATA_W-1:0]   wdata;
    } mu_req_t;

    // One per channel, pulses from the decoder
    typedef struct packed {
        logic start;
        logic cs_write;
        logic cs_value;
    } chan_cmd_t;

    typedef struct packed {
        logic [7:0] rx_byte;
        logic       cs;
        logic       irq;
        logic       done;
    } chan_stat_t;

endpackage

`default_nettype wire

//--- logic/memory_unit.sv
/*
 * Memory unit, peripheral I/O
 * CPU start/done bus into a bank of byte-wide SPI master channels,
 * a 4-bit GPO register, 4 GPI inputs and the boot-mode input
 */
`timescale 1ns/1ns
`default_nettype none

module memory_unit import mu_pkg::*; #(
    parameter int N_SPI             = 4,
    parameter int CLKS_PER_HALF_BIT = 2
) (
    input  wire                     clk,
    input  wire                     reset,

    // CPU bus
    input  wire [BUS_ADDR_W-1:0]    i_bus_addr,
    input  wire [BUS_DATA_W-1:0]    i_bus_data,
    input  wire                     i_bus_we,
    input  wire                     i_bus_start,
    output logic [BUS_DATA_W-1:0]   o_bus_q,
    output logic                    o_bus_done,

    // GPIO and boot
    input  wire [3:0]               i_gpi,
    input  wire                     i_boot_mode,
    output logic [3:0]              o_gpo,

    // SPI channels
    input  wire [N_SPI-1:0]         i_spi_miso,
    input  wire [N_SPI-1:0]         i_spi_irq,
    output logic [N_SPI-1:0]        o_spi_clk,
    output logic [N_SPI-1:0]        o_spi_mosi,
    output logic [N_SPI-1:0]        o_spi_cs
);

    mu_req_t                req;
    chan_cmd_t [N_SPI-1:0]  cmd;
    chan_stat_t [N_SPI-1:0] stat;
    logic                   load;

    mu_decoder #(
        .N_SPI          (N_SPI)
    ) decoder0 (
        .clk            (clk),
        .reset          (reset),
        .i_bus_addr     (i_bus_addr),
        .i_bus_data     (i_bus_data),
        .i_bus_we       (i_bus_we),
        .i_bus_start    (i_bus_start),
        .i_stat         (stat),
        .o_req          (req),
        .o_cmd          (cmd),
        .o_gpo          (o_gpo),
        .o_load         (load),
        .o_bus_done     (o_bus_done)
    );

    // ----------------------------------------
    // Identical SPI channels
    // ----------------------------------------
    for (genvar i = 0; i < N_SPI; i++)
    begin : g_spi
        spi_channel #(
            .CLKS_PER_HALF_BIT  (CLKS_PER_HALF_BIT)
        ) spi0 (
            .clk                (clk),
            .reset              (reset),
            .i_cmd              (cmd[i]),
            .i_wdata            (req.wdata[7:0]),
            .i_miso             (i_spi_miso[i]),
            .i_irq              (i_spi_irq[i]),
            .o_stat             (stat[i]),
            .o_spi_clk          (o_spi_clk[i]),
            .o_spi_mosi         (o_spi_mosi[i]),
            .o_spi_cs           (o_spi_cs[i])
        );
    end

    mu_readback #(
        .N_SPI          (N_SPI)
    ) readback0 (
        .clk            (clk),
        .reset          (reset),
        .i_req          (req),
        .i_stat         (stat),
        .i_gpo          (o_gpo),
        .i_gpi          (i_gpi),
        .i_boot_mode    (i_boot_mode),
        .i_load         (load),
        .o_bus_q        (o_bus_q)
    );

endmodule

`default_nettype wire

//--- logic/mu_decoder.sv
/*
 * Memory unit bus decoder
 * Maps each bus address to a select code and channel, issues one
 * command per access to the SPI channels, owns the GPO register and
 * sequences the load strobe and the done pulse back to the CPU
 */
`timescale 1ns/1ns
`default_nettype none

module mu_decoder import mu_pkg::*; #(
    parameter int N_SPI = 4
) (
    input  wire                         clk,
    input  wire                         reset,
    input  wire [BUS_ADDR_W-1:0]        i_bus_addr,
    input  wire [BUS_DATA_W-1:0]        i_bus_data,
    input  wire                         i_bus_we,
    input  wire                         i_bus_start,
    input  chan_stat_t [N_SPI-1:0]      i_stat,
    output mu_req_t                     o_req,
    output chan_cmd_t [N_SPI-1:0]       o_cmd,
    output logic [3:0]                  o_gpo,
    output logic                        o_load,
    output logic                        o_bus_done
);

    localparam logic [OFFSET_W-1:0] SPI_SPAN = OFFSET_W'(N_SPI * REGS_PER_CHAN);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_XFER,
        FINISH,
        DONE
    } state_e;

    state_e                 state;
    logic [BUS_ADDR_W-1:0]  addr_off;
    logic                   in_window;
    logic                   first;
    logic                   spi_write;
    logic                   xfer_done;

    // ----------------------------------------
    // Address decode
    // ----------------------------------------
    assign addr_off  = i_bus_addr - IO_BASE;
    assign in_window = (i_bus_addr >= IO_BASE) && (addr_off[BUS_ADDR_W-1:OFFSET_W] == '0);

    always_comb
    begin
        logic [OFFSET_W-1:0] idx;
        logic [OFFSET_W-1:0] idx_div;
        logic [OFFSET_W-1:0] idx_mod;

        idx     = addr_off[OFFSET_W-1:0];
        idx_div = idx / OFFSET_W'(REGS_PER_CHAN);
        idx_mod = idx % OFFSET_W'(REGS_PER_CHAN);

        o_req.sel   = SEL_NONE;
        o_req.chan  = '0;
        o_req.we    = i_bus_we;
        o_req.wdata = i_bus_data;

        if (in_window && idx < SPI_SPAN)
        begin
            o_req.chan = idx_div[CHAN_W-1:0];
            case (idx_mod)
                5'd0:    o_req.sel = SEL_SPI_DATA;
                5'd1:    o_req.sel = SEL_SPI_CS;
                default: o_req.sel = SEL_SPI_INT;
            endcase
        end
        else if (in_window && idx == GPIO_OFFSET)
        begin
            o_req.sel = SEL_GPIO;
        end
        else if (in_window && idx == BOOT_OFFSET)
        begin
            o_req.sel = SEL_BOOT;
        end
    end

    // Commands fire only on the cycle the access is first seen
    // Start is still held in the cycle after done
    assign first     = (state == IDLE) && i_bus_start && !o_bus_done;
    assign spi_write = (o_req.sel == SEL_SPI_DATA) && o_req.we;

    always_comb
    begin
        for (int i = 0; i < N_SPI; i++)
        begin
            o_cmd[i].start    = first && spi_write && (o_req.chan == CHAN_W'(i));
            o_cmd[i].cs_write = first && (o_req.sel == SEL_SPI_CS) && o_req.we
                                && (o_req.chan == CHAN_W'(i));
            o_cmd[i].cs_value = o_req.wdata[0];
        end
    end

    // ----------------------------------------
    // Completion sequencing
    // ----------------------------------------
    assign xfer_done = i_stat[o_req.chan].done;
    assign o_load    = (state == FINISH) || ((state == WAIT_XFER) && xfer_done);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state      <= IDLE;
            o_bus_done <= 1'b0;
            o_gpo      <= 4'd0;
        end
        else
        begin
            // Done follows the single DONE cycle
            o_bus_done <= (state == DONE);

            case (state)
                IDLE:
                begin
                    if (first)
                    begin
                        if (o_req.sel == SEL_GPIO && o_req.we)
                            o_gpo <= o_req.wdata[7:4];
                        state <= spi_write ? WAIT_XFER : FINISH;
                    end
                end
                WAIT_XFER:
                begin
                    if (xfer_done)
                        state <= DONE;
                end
                FINISH:
                begin
                    state <= DONE;
                end
                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/mu_readback.sv
/*
 * Memory unit read-back
 * Picks the read word by select code and channel and
 * holds it for the bus until the next access completes
 */
`timescale 1ns/1ns
`default_nettype none

module mu_readback import mu_pkg::*; #(
    parameter int N_SPI = 4
) (
    input  wire                         clk,
    input  wire                         reset,
    input  mu_req_t                     i_req,
    input  chan_stat_t [N_SPI-1:0]      i_stat,
    input  wire [3:0]                   i_gpo,
    input  wire [3:0]                   i_gpi,
    input  wire                         i_boot_mode,
    input  wire                         i_load,
    output logic [BUS_DATA_W-1:0]       o_bus_q
);

    logic [BUS_DATA_W-1:0] rd_word;
    chan_stat_t            chan_stat;

    assign chan_stat = i_stat[i_req.chan];

    always_comb
    begin
        case (i_req.sel)
            SEL_SPI_DATA: rd_word = BUS_DATA_W'(chan_stat.rx_byte);
            SEL_SPI_CS:   rd_word = BUS_DATA_W'(chan_stat.cs);
            SEL_SPI_INT:  rd_word = BUS_DATA_W'(chan_stat.irq);
            // GPO in the upper nibble, as written
            SEL_GPIO:     rd_word = BUS_DATA_W'({i_gpo, i_gpi});
            SEL_BOOT:     rd_word = BUS_DATA_W'(i_boot_mode);
            default:      rd_word = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            o_bus_q <= '0;
        else if (i_load)
            o_bus_q <= rd_word;
    end

endmodule

`default_nettype wire

//--- memory_unit.f
common/mu_pkg.sv
spi/spi_channel.sv
logic/mu_decoder.sv
logic/mu_readback.sv
logic/memory_unit.sv
verif/memory_unit_sva.sv
verif/memory_unit_tb.sv

//--- spi/spi_channel.sv
/*
 * SPI channel
 * Mode 0 byte master, MSB first, with its own chip-select register
 * and a two-flop synchronizer on the device interrupt input
 */
`timescale 1ns/1ns
`default_nettype none

module spi_channel import mu_pkg::*; #(
    parameter int CLKS_PER_HALF_BIT = 2
) (
    input  wire         clk,
    input  wire         reset,
    input  chan_cmd_t   i_cmd,
    input  wire [7:0]   i_wdata,
    input  wire         i_miso,
    input  wire         i_irq,
    output chan_stat_t  o_stat,
    output logic        o_spi_clk,
    output logic        o_spi_mosi,
    output logic        o_spi_cs
);

    localparam int CNT_W = (CLKS_PER_HALF_BIT > 1) ? $clog2(CLKS_PER_HALF_BIT) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_HALF_BIT - 1);

    logic               busy;
    logic [CNT_W-1:0]   clk_cnt;
    logic [3:0]         edge_cnt;
    logic               spi_clk_q;
    logic [7:0]         tx_q;
    logic [7:0]         rx_q;
    logic               done_q;
    logic               cs_q;
    logic               irq_meta;
    logic               irq_sync;

    // ----------------------------------------
    // Shift engine
    // ----------------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy      <= 1'b0;
            clk_cnt   <= '0;
            edge_cnt  <= 4'd0;
            spi_clk_q <= 1'b0;
            done_q    <= 1'b0;
        end
        else
        begin
            done_q <= 1'b0;

            if (!busy)
            begin
                // Held start from an ongoing access cannot reach here busy
                if (i_cmd.start)
                begin
                    busy     <= 1'b1;
                    clk_cnt  <= '0;
                    edge_cnt <= 4'd0;
                end
            end
            else if (clk_cnt == CNT_LAST)
            begin
                clk_cnt   <= '0;
                spi_clk_q <= ~spi_clk_q;
                edge_cnt  <= edge_cnt + 4'd1;
                // Sixteenth edge returns the clock low
                if (edge_cnt == 4'd15)
                begin
                    busy   <= 1'b0;
                    done_q <= 1'b1;
                end
            end
            else
            begin
                clk_cnt <= clk_cnt + CNT_W'(1);
            end
        end
    end

    // Payload shifters, MOSI changes on falling edges only
    always_ff @(posedge clk)
    begin
        if (!busy && i_cmd.start)
            tx_q <= i_wdata;
        else if (busy && clk_cnt == CNT_LAST && spi_clk_q)
            tx_q <= {tx_q[6:0], 1'b0};

        if (busy && clk_cnt == CNT_LAST && !spi_clk_q)
            rx_q <= {rx_q[6:0], i_miso};
    end

    // ----------------------------------------
    // Chip select and interrupt
    // ----------------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            cs_q     <= 1'b1;
            irq_meta <= 1'b0;
            irq_sync <= 1'b0;
        end
        else
        begin
            if (i_cmd.cs_write)
                cs_q <= i_cmd.cs_value;
            irq_meta <= i_irq;
            irq_sync <= irq_meta;
        end
    end

    assign o_spi_clk  = spi_clk_q;
    assign o_spi_mosi = tx_q[7];
    assign o_spi_cs   = cs_q;

    assign o_stat.rx_byte = rx_q;
    assign o_stat.cs      = cs_q;
    assign o_stat.irq     = irq_sync;
    assign o_stat.done    = done_q;

endmodule

`default_nettype wire

//--- verif/memory_unit_sva.sv
/*
 * Memory unit bus assertions
 * Bound to the decoder: done pulse width, done only during an
 * access, chip selects change only after a chip-select write
 */
`timescale 1ns/1ns
`default_nettype none

module memory_unit_sva import mu_pkg::*; #(
    parameter int N_SPI = 4
) (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     i_bus_start,
    input  wire                     o_bus_done,
    input  chan_stat_t [N_SPI-1:0]  i_stat,
    input  chan_cmd_t [N_SPI-1:0]   o_cmd
);

    a_done_pulse: assert property (@(posedge clk) disable iff (reset)
        o_bus_done |=> !o_bus_done)
        else $error("o_bus_done stayed high for more than one cycle");

    a_done_start: assert property (@(posedge clk) disable iff (reset)
        o_bus_done |-> i_bus_start)
        else $error("o_bus_done raised without i_bus_start");

    // Per channel chip-select register
    for (genvar i = 0; i < N_SPI; i++)
    begin : g_cs
        a_cs_write: assert property (@(posedge clk) disable iff (reset)
            !$stable(i_stat[i].cs) |-> $past(o_cmd[i].cs_write))
            else $error("chip select %0d changed without a write", i);
    end

endmodule

bind mu_decoder memory_unit_sva #(
    .N_SPI          (N_SPI)
) sva0 (
    .clk            (clk),
    .reset          (reset),
    .i_bus_start    (i_bus_start),
    .o_bus_done     (o_bus_done),
    .i_stat         (i_stat),
    .o_cmd          (o_cmd)
);

`default_nettype wire

//--- verif/memory_unit_tb.sv
/*
 * Memory unit testbench
 * Drives the CPU start/done bus, models one SPI slave per channel,
 * predicts every read word from its own record of the I/O state
 * and checks read data, pins and access latency
 */
`timescale 1ns/1ns
`default_nettype none

module memory_unit_tb import mu_pkg::*; ();

    localparam int N_SPI             = 4;
    localparam int CLKS_PER_HALF_BIT = 2;
    localparam int CLK_PERIOD        = 4;
    localparam int RESET_CYCLES      = 16;
    // Longest access plus the idle cycles around it
    localparam int WORST_CYCLES      = 16 * CLKS_PER_HALF_BIT + 8;
    localparam int WATCHDOG_NS       = CLK_PERIOD * (RESET_CYCLES + 200 * WORST_CYCLES);

    logic                   clk = 1'b0;
    logic                   reset;
    logic [BUS_ADDR_W-1:0]  bus_addr;
    logic [BUS_DATA_W-1:0]  bus_data;
    logic                   bus_we;
    logic                   bus_start;
    logic [3:0]             gpi;
    logic                   boot_mode;
    logic [N_SPI-1:0]       spi_irq;
    wire  [N_SPI-1:0]       spi_miso;
    logic [BUS_DATA_W-1:0]  bus_q;
    logic                   bus_done;
    logic [3:0]             gpo;
    logic [N_SPI-1:0]       spi_clk;
    logic [N_SPI-1:0]       spi_mosi;
    logic [N_SPI-1:0]       spi_cs;

    // Model of the I/O state
    logic [N_SPI-1:0]       m_cs;
    logic [3:0]             m_gpo;
    logic [7:0]             m_rx [N_SPI];
    logic [7:0]             slave_tx [N_SPI];
    wire  [7:0]             slave_rx [N_SPI];

    // Expected read word of the access in flight
    logic [BUS_DATA_W-1:0]  exp_q;
    logic [BUS_ADDR_W-1:0]  exp_addr;
    logic                   exp_check = 1'b0;

    int seed = 43;
    int errors = 0;
    int checks = 0;
    int q_errors = 0;
    int q_checks = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    memory_unit #(
        .N_SPI              (N_SPI),
        .CLKS_PER_HALF_BIT  (CLKS_PER_HALF_BIT)
    ) dut0 (
        .clk                (clk),
        .reset              (reset),
        .i_bus_addr         (bus_addr),
        .i_bus_data         (bus_data),
        .i_bus_we           (bus_we),
        .i_bus_start        (bus_start),
        .o_bus_q            (bus_q),
        .o_bus_done         (bus_done),
        .i_gpi              (gpi),
        .i_boot_mode        (boot_mode),
        .o_gpo              (gpo),
        .i_spi_miso         (spi_miso),
        .i_spi_irq          (spi_irq),
        .o_spi_clk          (spi_clk),
        .o_spi_mosi         (spi_mosi),
        .o_spi_cs           (spi_cs)
    );

    // ----------------------------------------
    // SPI slave models, mode 0
    // ----------------------------------------
    for (genvar c = 0; c < N_SPI; c++)
    begin : g_slave
        logic [2:0] bit_idx = 3'd0;
        logic [7:0] rx_sh = 8'd0;

        always @(posedge spi_clk[c])
        begin
            if (!reset)
                rx_sh <= {rx_sh[6:0], spi_mosi[c]};
        end

        // Next MISO bit after each falling edge, wraps after a byte
        always @(negedge spi_clk[c])
        begin
            if (!reset)
                bit_idx <= bit_idx + 3'd1;
        end

        assign spi_miso[c] = slave_tx[c][3'd7 - bit_idx];
        assign slave_rx[c] = rx_sh;
    end

    // ----------------------------------------
    // Reference model and helpers
    // ----------------------------------------
    function automatic logic [BUS_DATA_W-1:0] expected_read(input logic [BUS_ADDR_W-1:0] addr);
        int off;
        int chan;
        logic [BUS_DATA_W-1:0] word;

        word = '0;
        if (addr >= IO_BASE)
        begin
            off = int'(addr - IO_BASE);
            if (off < N_SPI * REGS_PER_CHAN)
            begin
                chan = off / REGS_PER_CHAN;
                case (off % REGS_PER_CHAN)
                    0:       word = {24'd0, m_rx[chan]};
                    1:       word = {31'd0, m_cs[chan]};
                    default: word = {31'd0, spi_irq[chan]};
                endcase
            end
            else if (off == int'(GPIO_OFFSET))
                word = {24'd0, m_gpo, gpi};
            else if (off == int'(BOOT_OFFSET))
                word = {31'd0, boot_mode};
        end
        return word;
    endfunction

    function automatic logic [BUS_ADDR_W-1:0] chan_addr(input int chan, input int reg_idx);
        return IO_BASE + BUS_ADDR_W'(chan * REGS_PER_CHAN + reg_idx);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Error: %s expected %h got %h", name, exp, got);
        end
    endtask

    // One bus access, returns once start has been dropped
    task automatic bus_access(input logic [BUS_ADDR_W-1:0] addr, input logic we,
                              input logic [BUS_DATA_W-1:0] data, input logic is_xfer);
        int lat;

        @(negedge clk);
        exp_q     = we ? '0 : expected_read(addr);
        exp_addr  = addr;
        exp_check = !we;
        bus_addr  = addr;
        bus_data  = data;
        bus_we    = we;
        bus_start = 1'b1;
        lat = 0;
        @(negedge clk);
        while (!bus_done)
        begin
            lat++;
            @(negedge clk);
        end
        @(negedge clk);
        bus_start = 1'b0;
        bus_we    = 1'b0;
        if (!is_xfer)
            check_value("register access latency", 32'(lat), 32'd2);
        if (is_xfer && lat < 16 * CLKS_PER_HALF_BIT)
        begin
            errors++;
            $display("Error: SPI write at %h ended after %0d cycles, before 16 SPI edges",
                     addr, lat);
        end
    endtask

    // Read data compare at every done pulse
    always @(negedge clk)
    begin
        if (!reset && bus_done && exp_check)
        begin
            q_checks++;
            if (bus_q !== exp_q)
            begin
                q_errors++;
                $display("Error: o_bus_q at address %h expected %h got %h",
                         exp_addr, exp_q, bus_q);
            end
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Error: watchdog expired before all bus accesses completed");
        $display("TEST FAILED");
        $finish;
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial
    begin
        logic [BUS_DATA_W-1:0] wd;

        reset     = 1'b1;
        bus_addr  = '0;
        bus_data  = '0;
        bus_we    = 1'b0;
        bus_start = 1'b0;
        gpi       = 4'd0;
        boot_mode = 1'b0;
        spi_irq   = '0;
        m_cs      = '1;
        m_gpo     = 4'd0;
        for (int c = 0; c < N_SPI; c++)
        begin
            slave_tx[c] = 8'd0;
            m_rx[c]     = 8'd0;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        // Reset values
        check_value("o_spi_cs", 32'(spi_cs), 32'({N_SPI{1'b1}}));
        check_value("o_spi_clk", 32'(spi_clk), 32'd0);
        check_value("o_gpo", 32'(gpo), 32'd0);
        check_value("o_bus_done", 32'(bus_done), 32'd0);
        check_value("o_bus_q", bus_q, 32'd0);
        for (int c = 0; c < N_SPI; c++)
            bus_access(chan_addr(c, 1), 1'b0, '0, 1'b0);

        // Chip selects, second round flips every one
        for (int round = 0; round < 2; round++)
        begin
            for (int c = 0; c < N_SPI; c++)
            begin
                wd = $random(seed);
                if (round == 1)
                    wd[0] = ~m_cs[c];
                m_cs[c] = wd[0];
                bus_access(chan_addr(c, 1), 1'b1, wd, 1'b0);
                check_value("o_spi_cs", 32'(spi_cs), 32'(m_cs));
            end
            for (int c = 0; c < N_SPI; c++)
                bus_access(chan_addr(c, 1), 1'b0, '0, 1'b0);
        end

        // SPI byte transfers
        for (int c = 0; c < N_SPI; c++)
        begin
            wd = $random(seed);
            slave_tx[c] = 8'($random(seed));
            bus_access(chan_addr(c, 0), 1'b1, wd, 1'b1);
            check_value("slave MOSI byte", 32'(slave_rx[c]), 32'(wd[7:0]));
            check_value("o_spi_clk", 32'(spi_clk), 32'd0);
            m_rx[c] = slave_tx[c];
            bus_access(chan_addr(c, 0), 1'b0, '0, 1'b0);
        end

        // GPIO, second round inverts every bit
        for (int round = 0; round < 2; round++)
        begin
            wd = $random(seed);
            if (round == 1)
            begin
                gpi = ~gpi;
                wd[7:4] = ~m_gpo;
            end
            else
            begin
                gpi = 4'($random(seed));
            end
            m_gpo = wd[7:4];
            bus_access(IO_BASE + BUS_ADDR_W'(GPIO_OFFSET), 1'b1, wd, 1'b0);
            check_value("o_gpo", 32'(gpo), 32'(m_gpo));
            bus_access(IO_BASE + BUS_ADDR_W'(GPIO_OFFSET), 1'b0, '0, 1'b0);
        end

        // Interrupts and boot mode, settled through the synchronizers
        for (int round = 0; round < 2; round++)
        begin
            if (round == 1)
            begin
                spi_irq = ~spi_irq;
                boot_mode = ~boot_mode;
            end
            else
            begin
                spi_irq = N_SPI'($random(seed));
                boot_mode = 1'($random(seed));
            end
            repeat (4) @(negedge clk);
            for (int c = 0; c < N_SPI; c++)
                bus_access(chan_addr(c, 2), 1'b0, '0, 1'b0);
            bus_access(IO_BASE + BUS_ADDR_W'(BOOT_OFFSET), 1'b0, '0, 1'b0);
        end

        // Unmapped addresses
        bus_access(IO_BASE - BUS_ADDR_W'(1), 1'b0, '0, 1'b0);
        bus_access(IO_BASE + BUS_ADDR_W'(14), 1'b0, '0, 1'b0);
        bus_access(IO_BASE + BUS_ADDR_W'(20), 1'b0, '0, 1'b0);
        bus_access(IO_BASE + BUS_ADDR_W'(20), 1'b1, 32'hFFFF_FFFF, 1'b0);
        check_value("o_spi_cs", 32'(spi_cs), 32'(m_cs));
        check_value("o_gpo", 32'(gpo), 32'(m_gpo));

        repeat (4) @(negedge clk);
        $display("Checks: %0d, errors: %0d", checks + q_checks, errors + q_errors);
        if (errors + q_errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire
